// ==== logic/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define DATA_W          32
`define REG_ADDR_W      5
`define REG_COUNT       32

`define RESET_PC        32'h0000_0000
`define PC_STEP         32'd4

// opcodes
`define OP_SPECIAL      6'b000000
`define OP_ADDIU        6'b001001
`define OP_ANDI         6'b001100
`define OP_ORI          6'b001101
`define OP_LUI          6'b001111
`define OP_LW           6'b100011
`define OP_SW           6'b101011

// funct field of OP_SPECIAL
`define FUNCT_ADDU      6'b100001
`define FUNCT_SUBU      6'b100011
`define FUNCT_AND       6'b100100
`define FUNCT_OR        6'b100101
`define FUNCT_XOR       6'b100110
`define FUNCT_SLT       6'b101010

`endif

// ==== logic/core_pkg.sv ====
`include "core_macros.svh"

package core_pkg;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // ALU_ADD must stay zero so a bubble decodes as a harmless add
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_LUI = 3'd6
    } alu_op_e;

    // fetch to decode
    typedef struct packed {
        word_t      pc;
        word_t      inst;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        alu_op_e    alu_op;
        word_t      operand_1;
        word_t      operand_2;
        word_t      store_data;
        reg_addr_t  dest;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        word_t      result;
        word_t      store_data;
        reg_addr_t  dest;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        word_t      data;
        reg_addr_t  dest;
        logic       reg_write;
    } wb_t;

endpackage

// ==== logic/stage_reg.sv ====
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = core_pkg::word_t
) (
    input  logic     clk,
    input  logic     arst_n_i,

    input  logic     hold_i,
    input  logic     bubble_i,

    input  payload_t d_i,
    output payload_t q_o
);

    // an all-zero payload is a bubble: no write, no memory access
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            if (bubble_i) begin
                q_o <= '0;
            end else begin
                q_o <= d_i;
            end
        end
    end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/10ps

`include "core_macros.svh"

module fetch_stage (
    input  logic            clk,
    input  logic            arst_n_i,

    input  logic            stall_i,

    output logic            rom_en_o,
    output core_pkg::word_t pc_o
);

    import core_pkg::*;

    word_t pc_next;

    assign pc_next = pc_o + `PC_STEP;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_en_o <= 1'b0;
        end else begin
            rom_en_o <= 1'b1;
        end
    end

    // pc only moves once the rom is enabled
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= `RESET_PC;
        end else if (rom_en_o && !stall_i) begin
            pc_o <= pc_next;
        end
    end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/10ps

`include "core_macros.svh"

module decode_stage (
    input  core_pkg::if_id_t    id_i,

    // register file read ports
    output core_pkg::reg_addr_t rd_addr_1_o,
    output core_pkg::reg_addr_t rd_addr_2_o,
    input  core_pkg::word_t     rd_data_1_i,
    input  core_pkg::word_t     rd_data_2_i,

    // forwarding sources
    input  core_pkg::ex_mem_t   ex_fwd_i,
    input  core_pkg::wb_t       mem_fwd_i,

    output logic                load_use_o,
    output core_pkg::id_ex_t    ex_o
);

    import core_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [15:0] imm;

    alu_op_e    alu_op;
    logic       use_imm;
    logic       sign_ext;
    logic       uses_rs;
    logic       uses_rt;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    reg_addr_t  dest;
    word_t      imm_ext;
    word_t      rs_val;
    word_t      rt_val;

    // newest producer wins, r0 is never forwarded
    function automatic word_t forward(reg_addr_t addr, word_t rf_data,
                                      ex_mem_t ex_src, wb_t mem_src);
        word_t val;
        val = rf_data;
        if (addr != '0 && ex_src.reg_write && ex_src.dest == addr) begin
            val = ex_src.result;
        end else if (addr != '0 && mem_src.reg_write && mem_src.dest == addr) begin
            val = mem_src.data;
        end
        return val;
    endfunction

    assign opcode = id_i.inst[31:26];
    assign rs     = id_i.inst[25:21];
    assign rt     = id_i.inst[20:16];
    assign rd     = id_i.inst[15:11];
    assign imm    = id_i.inst[15:0];
    assign funct  = id_i.inst[5:0];

    assign rd_addr_1_o = rs;
    assign rd_addr_2_o = rt;

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        sign_ext  = 1'b1;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        dest      = rt;
        case (opcode)
            `OP_SPECIAL: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                dest      = rd;
                reg_write = 1'b1;
                case (funct)
                    `FUNCT_ADDU: alu_op = ALU_ADD;
                    `FUNCT_SUBU: alu_op = ALU_SUB;
                    `FUNCT_AND:  alu_op = ALU_AND;
                    `FUNCT_OR:   alu_op = ALU_OR;
                    `FUNCT_XOR:  alu_op = ALU_XOR;
                    `FUNCT_SLT:  alu_op = ALU_SLT;
                    // unsupported funct, nop
                    default:     reg_write = 1'b0;
                endcase
            end
            `OP_ADDIU: begin
                use_imm   = 1'b1;
                uses_rs   = 1'b1;
                reg_write = 1'b1;
            end
            `OP_ANDI: begin
                alu_op    = ALU_AND;
                use_imm   = 1'b1;
                sign_ext  = 1'b0;
                uses_rs   = 1'b1;
                reg_write = 1'b1;
            end
            `OP_ORI: begin
                alu_op    = ALU_OR;
                use_imm   = 1'b1;
                sign_ext  = 1'b0;
                uses_rs   = 1'b1;
                reg_write = 1'b1;
            end
            `OP_LUI: begin
                alu_op    = ALU_LUI;
                use_imm   = 1'b1;
                sign_ext  = 1'b0;
                reg_write = 1'b1;
            end
            `OP_LW: begin
                use_imm   = 1'b1;
                uses_rs   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            `OP_SW: begin
                use_imm   = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                mem_write = 1'b1;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

    assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    assign rs_val = forward(rs, rd_data_1_i, ex_fwd_i, mem_fwd_i);
    assign rt_val = forward(rt, rd_data_2_i, ex_fwd_i, mem_fwd_i);

    // load data is only ready once the load leaves execute
    assign load_use_o = ex_fwd_i.mem_read && ex_fwd_i.dest != '0 &&
                        ((uses_rs && ex_fwd_i.dest == rs) ||
                         (uses_rt && ex_fwd_i.dest == rt));

    always_comb begin
        ex_o.alu_op     = alu_op;
        ex_o.operand_1  = rs_val;
        ex_o.operand_2  = use_imm ? imm_ext : rt_val;
        ex_o.store_data = rt_val;
        ex_o.dest       = dest;
        ex_o.reg_write  = reg_write;
        ex_o.mem_read   = mem_read;
        ex_o.mem_write  = mem_write;
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps

`include "core_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n_i,

    input  core_pkg::reg_addr_t rd_addr_1_i,
    input  core_pkg::reg_addr_t rd_addr_2_i,
    output core_pkg::word_t     rd_data_1_o,
    output core_pkg::word_t     rd_data_2_o,

    input  core_pkg::wb_t       wb_i
);

    import core_pkg::*;

    word_t regs [`REG_COUNT];

    // r0 reads zero, a same-cycle write is seen at once
    function automatic word_t read_port(reg_addr_t addr, word_t stored, wb_t wb);
        word_t val;
        val = stored;
        if (addr == '0) begin
            val = '0;
        end else if (wb.reg_write && wb.dest == addr) begin
            val = wb.data;
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.reg_write && wb_i.dest != '0) begin
            regs[wb_i.dest] <= wb_i.data;
        end
    end

    assign rd_data_1_o = read_port(rd_addr_1_i, regs[rd_addr_1_i], wb_i);
    assign rd_data_2_o = read_port(rd_addr_2_i, regs[rd_addr_2_i], wb_i);

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  core_pkg::id_ex_t  ex_i,
    output core_pkg::ex_mem_t mem_o
);

    import core_pkg::*;

    word_t result;
    logic  less;

    // signed compare for slt
    assign less = $signed(ex_i.operand_1) < $signed(ex_i.operand_2);

    // lw and sw come in as ALU_ADD, so result is the address
    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD: result = ex_i.operand_1 + ex_i.operand_2;
            ALU_SUB: result = ex_i.operand_1 - ex_i.operand_2;
            ALU_AND: result = ex_i.operand_1 & ex_i.operand_2;
            ALU_OR:  result = ex_i.operand_1 | ex_i.operand_2;
            ALU_XOR: result = ex_i.operand_1 ^ ex_i.operand_2;
            ALU_SLT: result = {31'b0, less};
            ALU_LUI: result = {ex_i.operand_2[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    always_comb begin
        mem_o.result     = result;
        mem_o.store_data = ex_i.store_data;
        mem_o.dest       = ex_i.dest;
        mem_o.reg_write  = ex_i.reg_write;
        mem_o.mem_read   = ex_i.mem_read;
        mem_o.mem_write  = ex_i.mem_write;
    end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage (
    input  core_pkg::ex_mem_t mem_i,

    // data RAM, whole words only
    output logic              ram_en_o,
    output logic              ram_write_en_o,
    output core_pkg::word_t   ram_addr_o,
    output core_pkg::word_t   ram_write_data_o,
    input  core_pkg::word_t   ram_read_data_i,

    output core_pkg::wb_t     wb_o
);

    assign ram_en_o         = mem_i.mem_read | mem_i.mem_write;
    assign ram_write_en_o   = mem_i.mem_write;
    assign ram_addr_o       = mem_i.result;
    assign ram_write_data_o = mem_i.store_data;

    // load data replaces the address
    always_comb begin
        wb_o.data      = mem_i.mem_read ? ram_read_data_i : mem_i.result;
        wb_o.dest      = mem_i.dest;
        wb_o.reg_write = mem_i.reg_write;
    end

endmodule

// ==== logic/mips_core.sv ====
`timescale 1ns/10ps

module mips_core (
    input  logic            clk,
    input  logic            arst_n_i,

    // instruction ROM
    input  core_pkg::word_t rom_inst_i,
    output core_pkg::word_t rom_addr_o,
    output logic            rom_en_o,

    // data RAM
    output logic            ram_en_o,
    output logic            ram_write_en_o,
    output core_pkg::word_t ram_addr_o,
    output core_pkg::word_t ram_write_data_o,
    input  core_pkg::word_t ram_read_data_i
);

    import core_pkg::*;

    if_id_t    if_d;
    if_id_t    id_q;
    id_ex_t    id_ex_d;
    id_ex_t    ex_q;
    ex_mem_t   ex_mem_d;
    ex_mem_t   mem_q;
    wb_t       mem_wb_d;
    wb_t       wb_q;

    reg_addr_t rd_addr_1;
    reg_addr_t rd_addr_2;
    word_t     rd_data_1;
    word_t     rd_data_2;
    logic      load_use;

    assign if_d = '{pc: rom_addr_o, inst: rom_inst_i};

    fetch_stage fetch0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (load_use),
        .rom_en_o (rom_en_o),
        .pc_o     (rom_addr_o)
    );

    // nothing valid enters until the rom is enabled
    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (load_use),
        .bubble_i (!rom_en_o),
        .d_i      (if_d),
        .q_o      (id_q)
    );

    decode_stage decode0 (
        .id_i        (id_q),
        .rd_addr_1_o (rd_addr_1),
        .rd_addr_2_o (rd_addr_2),
        .rd_data_1_i (rd_data_1),
        .rd_data_2_i (rd_data_2),
        .ex_fwd_i    (ex_mem_d),
        .mem_fwd_i   (mem_wb_d),
        .load_use_o  (load_use),
        .ex_o        (id_ex_d)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .bubble_i (load_use),
        .d_i      (id_ex_d),
        .q_o      (ex_q)
    );

    execute_stage execute0 (
        .ex_i  (ex_q),
        .mem_o (ex_mem_d)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .bubble_i (1'b0),
        .d_i      (ex_mem_d),
        .q_o      (mem_q)
    );

    memory_stage memory0 (
        .mem_i            (mem_q),
        .ram_en_o         (ram_en_o),
        .ram_write_en_o   (ram_write_en_o),
        .ram_addr_o       (ram_addr_o),
        .ram_write_data_o (ram_write_data_o),
        .ram_read_data_i  (ram_read_data_i),
        .wb_o             (mem_wb_d)
    );

    stage_reg #(.payload_t(wb_t)) mem_wb_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .bubble_i (1'b0),
        .d_i      (mem_wb_d),
        .q_o      (wb_q)
    );

    reg_file reg_file0 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rd_addr_1_i (rd_addr_1),
        .rd_addr_2_i (rd_addr_2),
        .rd_data_1_o (rd_data_1),
        .rd_data_2_o (rd_data_2),
        .wb_i        (wb_q)
    );

endmodule

// ==== verif/mips_core_sva.sv ====
`timescale 1ns/10ps

module mips_core_sva (
    input logic            clk,
    input logic            arst_n_i,
    input logic            ram_en_i,
    input logic            ram_write_en_i,
    input core_pkg::word_t rom_addr_i,
    input logic            load_use_i
);

    // a write is always an enabled access
    write_needs_enable: assert property (
        @(posedge clk) disable iff (!arst_n_i) ram_write_en_i |-> ram_en_i
    ) else $error("ram_write_en_o high while ram_en_o is low");

    // ram stays idle while the core is in reset
    idle_in_reset: assert property (
        @(posedge clk) !arst_n_i |-> (!ram_en_i && !ram_write_en_i)
    ) else $error("RAM enabled during reset");

    // pc holds for the cycle after a load-use stall
    pc_holds_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n_i) load_use_i |=> $stable(rom_addr_i)
    ) else $error("rom_addr_o moved after a load-use stall");

endmodule

bind mips_core mips_core_sva sva_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .ram_en_i       (ram_en_o),
    .ram_write_en_i (ram_write_en_o),
    .rom_addr_i     (rom_addr_o),
    .load_use_i     (load_use)
);

// ==== verif/mips_core_tb.sv ====
`timescale 1ns/10ps

`include "core_macros.svh"

module mips_core_tb;

    import core_pkg::*;

    localparam int    NUM_TESTS = 15;
    localparam int    MEM_WORDS = 256;
    localparam word_t NOP       = 32'h0000_0000;

    typedef enum logic [3:0] {
        K_ADDU, K_SUBU, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDIU, K_ANDI, K_ORI, K_LUI, K_LOAD_USE, K_ZERO
    } kind_e;

    // gap is the count of nops before the closing sw
    typedef struct packed {
        kind_e      kind;
        logic [1:0] gap;
        word_t      addr;
    } test_row_t;

    test_row_t table_rows [NUM_TESTS] = '{
        '{K_ADDU,     2'd0, 32'h0000_0100},
        '{K_SUBU,     2'd0, 32'h0000_0104},
        '{K_AND,      2'd0, 32'h0000_0108},
        '{K_OR,       2'd0, 32'h0000_010c},
        '{K_XOR,      2'd0, 32'h0000_0110},
        '{K_SLT,      2'd0, 32'h0000_0114},
        '{K_SLT,      2'd0, 32'h0000_0118},
        '{K_ADDU,     2'd1, 32'h0000_011c},
        '{K_XOR,      2'd2, 32'h0000_0120},
        '{K_ADDIU,    2'd0, 32'h0000_0124},
        '{K_ANDI,     2'd0, 32'h0000_0128},
        '{K_ORI,      2'd0, 32'h0000_012c},
        '{K_LUI,      2'd0, 32'h0000_0130},
        '{K_LOAD_USE, 2'd0, 32'h0000_0134},
        '{K_ZERO,     2'd0, 32'h0000_0138}
    };

    logic        clk = 1'b0;
    logic        arst_n_i = 1'b0;
    word_t       rom_inst;
    word_t       rom_addr;
    logic        rom_en;
    logic        ram_en;
    logic        ram_write_en;
    word_t       ram_addr;
    word_t       ram_write_data;
    word_t       ram_read_data;

    word_t       rom [MEM_WORDS];
    word_t       ram [MEM_WORDS];
    word_t       exp_data [NUM_TESTS];
    logic [31:0] lfsr_state = 32'h6cd0717e;
    int          prog_len = 0;
    int          stalls = 0;
    int          cycle = 0;
    int          cycle_limit = 0;
    int          store_count = 0;
    int          passed = 0;
    int          failed = 0;
    int          other_errors = 0;

    always #20 clk = ~clk;

    mips_core dut_i (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .rom_inst_i       (rom_inst),
        .rom_addr_o       (rom_addr),
        .rom_en_o         (rom_en),
        .ram_en_o         (ram_en),
        .ram_write_en_o   (ram_write_en),
        .ram_addr_o       (ram_addr),
        .ram_write_data_o (ram_write_data),
        .ram_read_data_i  (ram_read_data)
    );

    // both memories read asynchronously, the RAM only when enabled
    assign rom_inst      = rom[rom_addr[9:2]];
    assign ram_read_data = ram_en ? ram[ram_addr[9:2]] : 'x;

    always @(posedge clk) begin
        if (ram_write_en) begin
            ram[ram_addr[9:2]] <= ram_write_data;
        end
    end

    always @(posedge clk) begin
        if (arst_n_i) begin
            cycle <= cycle + 1;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output word_t val);
        val = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic word_t enc_r(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt,
                                    reg_addr_t rd);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] funct_of(kind_e kind);
        case (kind)
            K_SUBU:  return `FUNCT_SUBU;
            K_AND:   return `FUNCT_AND;
            K_OR:    return `FUNCT_OR;
            K_XOR:   return `FUNCT_XOR;
            K_SLT:   return `FUNCT_SLT;
            default: return `FUNCT_ADDU;
        endcase
    endfunction

    function automatic logic [5:0] opcode_of(kind_e kind);
        case (kind)
            K_ANDI:  return `OP_ANDI;
            K_ORI:   return `OP_ORI;
            default: return `OP_ADDIU;
        endcase
    endfunction

    // stored value per the instruction rules, b carries the immediate
    function automatic word_t expected_value(kind_e kind, word_t a, word_t b);
        word_t sext;
        word_t zext;
        sext = {{16{b[15]}}, b[15:0]};
        zext = {16'h0000, b[15:0]};
        case (kind)
            K_ADDU:     return a + b;
            K_SUBU:     return a - b;
            K_AND:      return a & b;
            K_OR:       return a | b;
            K_XOR:      return a ^ b;
            K_SLT:      return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDIU:    return a + sext;
            K_ANDI:     return a & zext;
            K_ORI:      return a | zext;
            K_LUI:      return {b[15:0], 16'h0000};
            K_LOAD_USE: return a + a;
            default:    return '0;
        endcase
    endfunction

    task automatic emit(input word_t inst);
        rom[prog_len] = inst;
        prog_len++;
    endtask

    task automatic assemble_row(input int k);
        test_row_t row;
        word_t     a;
        word_t     b;
        reg_addr_t src;
        row = table_rows[k];
        draw_word(a);
        draw_word(b);
        src = 5'd3;
        if (row.kind == K_LOAD_USE) begin
            // reload the previous slot and use it at once
            emit(enc_i(`OP_LW, 5'd0, 5'd4, table_rows[k-1].addr[15:0]));
            emit(enc_r(`FUNCT_ADDU, 5'd4, 5'd4, 5'd5));
            a = exp_data[k-1];
            src = 5'd5;
            stalls++;
        end else if (row.kind == K_ZERO) begin
            emit(enc_i(`OP_ADDIU, 5'd0, 5'd0, b[15:0]));
            src = 5'd0;
        end else begin
            if (row.kind == K_SLT) begin
                // opposite signs, signed and unsigned compares disagree
                b[31] = ~a[31];
            end else if (row.kind >= K_ADDIU) begin
                b[15] = 1'b1;
            end
            emit(enc_i(`OP_LUI, 5'd0, 5'd1, a[31:16]));
            emit(enc_i(`OP_ORI, 5'd1, 5'd1, a[15:0]));
            if (row.kind < K_ADDIU) begin
                emit(enc_i(`OP_LUI, 5'd0, 5'd2, b[31:16]));
                emit(enc_i(`OP_ORI, 5'd2, 5'd2, b[15:0]));
                emit(enc_r(funct_of(row.kind), 5'd1, 5'd2, 5'd3));
            end else if (row.kind == K_LUI) begin
                emit(enc_i(`OP_LUI, 5'd0, 5'd3, b[15:0]));
            end else begin
                emit(enc_i(opcode_of(row.kind), 5'd1, 5'd3, b[15:0]));
            end
        end
        repeat (row.gap) emit(NOP);
        emit(enc_i(`OP_SW, 5'd0, src, row.addr[15:0]));
        exp_data[k] = expected_value(row.kind, a, b);
    endtask

    task automatic check_addr(input word_t got, input word_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("[ERROR] ram_addr_o: got 0x%08h, expected 0x%08h", got, exp);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("[ERROR] ram_write_data_o: got 0x%08h, expected 0x%08h", got, exp);
        end
    endtask

    task automatic check_rom_en(input logic got, input logic exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("[ERROR] rom_en_o: got 0x%0h, expected 0x%0h", got, exp);
        end
    endtask

    task automatic check_store(input int k, input word_t addr, input word_t data);
        bit    addr_ok;
        bit    data_ok;
        kind_e kind;
        kind = table_rows[k].kind;
        check_addr(addr, table_rows[k].addr, addr_ok);
        check_word(data, exp_data[k], data_ok);
        if (addr_ok && data_ok) begin
            passed++;
            $display("test %0d %s: ok, 0x%08h at 0x%08h", k, kind.name(), data, addr);
        end else begin
            failed++;
            $display("test %0d %s: wrong store", k, kind.name());
        end
    endtask

    always @(negedge clk) begin
        bit en_ok;
        // rom enable rises on the first edge after reset release
        check_rom_en(rom_en, cycle != 0, en_ok);
        if (!en_ok) begin
            other_errors++;
        end
        if (ram_write_en) begin
            if (cycle == 0) begin
                $display("a RAM write happened during reset or in the first cycle after it");
                other_errors++;
            end else if (store_count >= NUM_TESTS) begin
                $display("an extra store to 0x%08h arrived after the last test", ram_addr);
                other_errors++;
            end else begin
                check_store(store_count, ram_addr, ram_write_data);
                store_count++;
            end
        end
    end

    initial begin
        int missing;
        missing = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = NOP;
            ram[i] <= 32'h5eed_0000 + i;
        end
        for (int k = 0; k < NUM_TESTS; k++) begin
            assemble_row(k);
        end
        cycle_limit = prog_len + stalls + 20;
        $display("%0d instructions, %0d load-use stalls, limit %0d cycles",
                 prog_len, stalls, cycle_limit);

        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;

        while (store_count < NUM_TESTS && cycle < cycle_limit) begin
            @(posedge clk);
        end
        if (store_count < NUM_TESTS) begin
            $display("the cycle limit of %0d was reached before all stores arrived",
                     cycle_limit);
            for (int k = store_count; k < NUM_TESTS; k++) begin
                $display("test %0d never stored its result", k);
                missing++;
            end
        end else begin
            // room for a repeated store to show up
            repeat (4) @(posedge clk);
        end

        $display("%0d passed, %0d failed, %0d missing, %0d other errors",
                 passed, failed, missing, other_errors);
        if (failed == 0 && missing == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/core_pkg.sv
logic/stage_reg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_core.sv
verif/mips_core_sva.sv
verif/mips_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= mips_core_tb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
